//--- id_pkg.sv
`default_nettype none

package id_pkg;

    // ====================
    // Widths
    // ====================
    localparam int XLEN      = 64;
    localparam int REG_IDX_W = 5;
    localparam int INST_W    = 32;

    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_BRANCH = 7'b1100011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_IMM    = 7'b0010011,
        OP_OP     = 7'b0110011
    } opcode_e;

    typedef enum logic [2:0] {IMM_NONE, IMM_I, IMM_S, IMM_B, IMM_U, IMM_J} imm_type_e;
    typedef enum logic [2:0] {EQ, NE, LT, GE, LTU, GEU} comp_type_e;
    typedef enum logic [3:0] {ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND} alu_op_e;
    typedef enum logic [1:0] {BYTE, HALF, WORD, DOUBLE} mem_size_e;  // Same as funct3[1:0].
    typedef enum logic [1:0] {SRC_REG, SRC_ID2EX, SRC_EX2MEM, SRC_MEM2WB} src_sel_e;

    // ====================
    // Instruction formats
    // ====================
    typedef struct packed {
        logic [6:0]           funct7;
        logic [REG_IDX_W-1:0] rs2;
        logic [REG_IDX_W-1:0] rs1;
        logic [2:0]           funct3;
        logic [REG_IDX_W-1:0] rd;
        logic [6:0]           opcode;
    } inst_r_t;

    typedef struct packed {
        logic [11:0]          imm_11_0;
        logic [REG_IDX_W-1:0] rs1;
        logic [2:0]           funct3;
        logic [REG_IDX_W-1:0] rd;
        logic [6:0]           opcode;
    } inst_i_t;

    typedef struct packed {
        logic [6:0]           imm_11_5;
        logic [REG_IDX_W-1:0] rs2;
        logic [REG_IDX_W-1:0] rs1;
        logic [2:0]           funct3;
        logic [4:0]           imm_4_0;
        logic [6:0]           opcode;
    } inst_s_t;

    typedef struct packed {
        logic                 imm_12;
        logic [5:0]           imm_10_5;
        logic [REG_IDX_W-1:0] rs2;
        logic [REG_IDX_W-1:0] rs1;
        logic [2:0]           funct3;
        logic [3:0]           imm_4_1;
        logic                 imm_11;
        logic [6:0]           opcode;
    } inst_b_t;

    typedef struct packed {
        logic [19:0]          imm_31_12;
        logic [REG_IDX_W-1:0] rd;
        logic [6:0]           opcode;
    } inst_u_t;

    typedef struct packed {
        logic                 imm_20;
        logic [9:0]           imm_10_1;
        logic                 imm_11;
        logic [7:0]           imm_19_12;
        logic [REG_IDX_W-1:0] rd;
        logic [6:0]           opcode;
    } inst_j_t;

    typedef union packed {
        inst_r_t r;
        inst_i_t i;
        inst_s_t s;
        inst_b_t b;
        inst_u_t u;
        inst_j_t j;
    } inst_t;

    // ====================
    // Bundles
    // ====================
    typedef struct packed {
        logic       rs1_en;
        logic       rs2_en;
        logic       rd_en;
        logic       inst_jump;
        logic       inst_branch;
        logic       inst_lui;
        logic       jump_base_rs1;  // JALR only.
        logic       alu_src_imm;
        alu_op_e    alu_op;
        logic       mem_read;
        logic       mem_write;
        mem_size_e  mem_size;
        logic       load_unsigned;
        comp_type_e comp_type;
        imm_type_e  imm_type;
    } ctrl_t;

    typedef struct packed {
        logic                 rd_en;
        logic [REG_IDX_W-1:0] rd_index;
        logic [XLEN-1:0]      rd_data;
    } wb_bus_t;

    typedef struct packed {
        src_sel_e rs1_src;
        src_sel_e rs2_src;
    } fwd_sel_t;

endpackage

`default_nettype wire

//--- id_control.sv
`timescale 1ns/1ns
`default_nettype none

module id_control import id_pkg::*; (
    input  wire         clk,
    input  wire         arst_n_i,
    input  wire         inst_valid_i,
    input  wire inst_t  inst_i,
    output ctrl_t       ctrl_o
);

    function automatic alu_op_e alu_decode(input logic [2:0] funct3,
                                           input logic       alt,
                                           input logic       reg_op);
        alu_op_e op;
        case (funct3)
            3'b000:  op = (alt && reg_op) ? SUB : ADD;  // No SUBI.
            3'b001:  op = SLL;
            3'b010:  op = SLT;
            3'b011:  op = SLTU;
            3'b100:  op = XOR;
            3'b101:  op = alt ? SRA : SRL;
            3'b110:  op = OR;
            default: op = AND;
        endcase
        return op;
    endfunction

    always_comb begin
        ctrl_o = '0;
        if (inst_valid_i) begin
            case (inst_i.r.opcode)
                OP_LUI: begin
                    ctrl_o.rd_en    = 1'b1;
                    ctrl_o.inst_lui = 1'b1;
                    ctrl_o.imm_type = IMM_U;
                end
                OP_JAL: begin
                    ctrl_o.rd_en     = 1'b1;
                    ctrl_o.inst_jump = 1'b1;
                    ctrl_o.imm_type  = IMM_J;
                end
                OP_JALR: begin
                    ctrl_o.rs1_en        = 1'b1;
                    ctrl_o.rd_en         = 1'b1;
                    ctrl_o.inst_jump     = 1'b1;
                    ctrl_o.jump_base_rs1 = 1'b1;
                    ctrl_o.imm_type      = IMM_I;
                end
                OP_BRANCH: begin
                    ctrl_o.rs1_en   = 1'b1;
                    ctrl_o.rs2_en   = 1'b1;
                    ctrl_o.imm_type = IMM_B;
                    ctrl_o.inst_branch = 1'b1;
                    case (inst_i.b.funct3)
                        3'b000:  ctrl_o.comp_type = EQ;
                        3'b001:  ctrl_o.comp_type = NE;
                        3'b100:  ctrl_o.comp_type = LT;
                        3'b101:  ctrl_o.comp_type = GE;
                        3'b110:  ctrl_o.comp_type = LTU;
                        3'b111:  ctrl_o.comp_type = GEU;
                        default: ctrl_o.inst_branch = 1'b0;  // Reserved funct3.
                    endcase
                end
                OP_LOAD: begin
                    ctrl_o.rs1_en        = 1'b1;
                    ctrl_o.rd_en         = 1'b1;
                    ctrl_o.alu_src_imm   = 1'b1;
                    ctrl_o.alu_op        = ADD;
                    ctrl_o.mem_read      = 1'b1;
                    ctrl_o.mem_size      = mem_size_e'(inst_i.i.funct3[1:0]);
                    ctrl_o.load_unsigned = inst_i.i.funct3[2];
                    ctrl_o.imm_type      = IMM_I;
                end
                OP_STORE: begin
                    ctrl_o.rs1_en      = 1'b1;
                    ctrl_o.rs2_en      = 1'b1;
                    ctrl_o.alu_src_imm = 1'b1;
                    ctrl_o.alu_op      = ADD;
                    ctrl_o.mem_write   = 1'b1;
                    ctrl_o.mem_size    = mem_size_e'(inst_i.s.funct3[1:0]);
                    ctrl_o.imm_type    = IMM_S;
                end
                OP_IMM: begin
                    ctrl_o.rs1_en      = 1'b1;
                    ctrl_o.rd_en       = 1'b1;
                    ctrl_o.alu_src_imm = 1'b1;
                    ctrl_o.alu_op      = alu_decode(inst_i.r.funct3, inst_i.r.funct7[5], 1'b0);
                    ctrl_o.imm_type    = IMM_I;
                end
                OP_OP: begin
                    ctrl_o.rs1_en = 1'b1;
                    ctrl_o.rs2_en = 1'b1;
                    ctrl_o.rd_en  = 1'b1;
                    ctrl_o.alu_op = alu_decode(inst_i.r.funct3, inst_i.r.funct7[5], 1'b1);
                end
                default: ctrl_o = '0;  // Unknown opcode.
            endcase
        end
    end

    a_mem_excl: assert property (@(posedge clk) disable iff (!arst_n_i)
        !(ctrl_o.mem_read && ctrl_o.mem_write));

endmodule

`default_nettype wire

//--- id_immgen.sv
`timescale 1ns/1ns
`default_nettype none

module id_immgen import id_pkg::*; (
    input  wire imm_type_e   imm_type_i,
    input  wire inst_t       inst_i,
    output logic [XLEN-1:0]  imm_data_o
);

    always_comb begin
        case (imm_type_i)
            IMM_I: imm_data_o = {{(XLEN-12){inst_i.i.imm_11_0[11]}}, inst_i.i.imm_11_0};
            IMM_S: imm_data_o = {{(XLEN-12){inst_i.s.imm_11_5[6]}},
                                 inst_i.s.imm_11_5, inst_i.s.imm_4_0};
            IMM_B: imm_data_o = {{(XLEN-13){inst_i.b.imm_12}}, inst_i.b.imm_12,
                                 inst_i.b.imm_11, inst_i.b.imm_10_5,
                                 inst_i.b.imm_4_1, 1'b0};
            // Upper 20 bits of the word, low 12 cleared.
            IMM_U: imm_data_o = {{(XLEN-INST_W){inst_i.u.imm_31_12[19]}},
                                 inst_i.u.imm_31_12, 12'b0};
            IMM_J: imm_data_o = {{(XLEN-21){inst_i.j.imm_20}}, inst_i.j.imm_20,
                                 inst_i.j.imm_19_12, inst_i.j.imm_11,
                                 inst_i.j.imm_10_1, 1'b0};
            default: imm_data_o = '0;  // IMM_NONE.
        endcase
    end

endmodule

`default_nettype wire

//--- id_regfile.sv
`timescale 1ns/1ns
`default_nettype none

module id_regfile import id_pkg::*; (
    input  wire                  clk,
    input  wire                  arst_n_i,
    input  wire wb_bus_t         wb_i,
    input  wire [REG_IDX_W-1:0]  rs1_index_i,
    input  wire [REG_IDX_W-1:0]  rs2_index_i,
    output logic [XLEN-1:0]      rs1_data_o,
    output logic [XLEN-1:0]      rs2_data_o
);

    logic [XLEN-1:0] regs [0:31];  // x0 is cleared and never written.

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_i.rd_en && (wb_i.rd_index != '0)) begin
            regs[wb_i.rd_index] <= wb_i.rd_data;
        end
    end

    // Same-cycle write is covered by mem2wb forwarding.
    assign rs1_data_o = regs[rs1_index_i];
    assign rs2_data_o = regs[rs2_index_i];

    a_x0_zero: assert property (@(posedge clk) disable iff (!arst_n_i)
        ((rs1_index_i == '0) |-> (rs1_data_o == '0)) and
        ((rs2_index_i == '0) |-> (rs2_data_o == '0)));

endmodule

`default_nettype wire

//--- id_forward.sv
`timescale 1ns/1ns
`default_nettype none

module id_forward import id_pkg::*; (
    input  wire                  clk,
    input  wire                  rs1_en_i,
    input  wire                  rs2_en_i,
    input  wire [REG_IDX_W-1:0]  rs1_index_i,
    input  wire [REG_IDX_W-1:0]  rs2_index_i,
    input  wire wb_bus_t         id2ex_i,
    input  wire wb_bus_t         ex2mem_i,
    input  wire wb_bus_t         mem2wb_i,
    output fwd_sel_t             fwd_sel_o
);

    // Youngest matching stage wins.
    function automatic src_sel_e pick_src(input logic                 en,
                                          input logic [REG_IDX_W-1:0] idx,
                                          input wb_bus_t              b_id2ex,
                                          input wb_bus_t              b_ex2mem,
                                          input wb_bus_t              b_mem2wb);
        src_sel_e sel;
        sel = SRC_REG;
        if (en && (idx != '0)) begin
            if (b_id2ex.rd_en && (b_id2ex.rd_index == idx)) begin
                sel = SRC_ID2EX;
            end else if (b_ex2mem.rd_en && (b_ex2mem.rd_index == idx)) begin
                sel = SRC_EX2MEM;
            end else if (b_mem2wb.rd_en && (b_mem2wb.rd_index == idx)) begin
                sel = SRC_MEM2WB;
            end
        end
        return sel;
    endfunction

    assign fwd_sel_o.rs1_src = pick_src(rs1_en_i, rs1_index_i, id2ex_i, ex2mem_i, mem2wb_i);
    assign fwd_sel_o.rs2_src = pick_src(rs2_en_i, rs2_index_i, id2ex_i, ex2mem_i, mem2wb_i);

    a_x0_no_fwd: assert property (@(posedge clk)
        ((rs1_index_i == '0) |-> (fwd_sel_o.rs1_src == SRC_REG)) and
        ((rs2_index_i == '0) |-> (fwd_sel_o.rs2_src == SRC_REG)));

endmodule

`default_nettype wire

//--- id_branchjudge.sv
`timescale 1ns/1ns
`default_nettype none

module id_branchjudge import id_pkg::*; (
    input  wire comp_type_e       comp_type_i,
    input  wire [XLEN-1:0]        rs1_data_i,
    input  wire [XLEN-1:0]        rs2_data_i,
    output logic                  taken_o
);

    always_comb begin
        case (comp_type_i)
            EQ:      taken_o = (rs1_data_i == rs2_data_i);
            NE:      taken_o = (rs1_data_i != rs2_data_i);
            LT:      taken_o = ($signed(rs1_data_i) < $signed(rs2_data_i));
            GE:      taken_o = ($signed(rs1_data_i) >= $signed(rs2_data_i));
            LTU:     taken_o = (rs1_data_i < rs2_data_i);
            GEU:     taken_o = (rs1_data_i >= rs2_data_i);
            default: taken_o = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

//--- id_top.sv
`timescale 1ns/1ns
`default_nettype none

module id_top import id_pkg::*; (
    input  wire                  clk,
    input  wire                  arst_n_i,
    input  wire                  inst_valid_i,
    input  wire inst_t           inst_i,
    input  wire [XLEN-1:0]       inst_addr_i,
    input  wire [XLEN-1:0]       nxt_inst_addr_i,
    input  wire wb_bus_t         id2ex_i,
    input  wire wb_bus_t         ex2mem_i,
    input  wire wb_bus_t         mem2wb_i,  // Also the write-back port.
    output ctrl_t                ctrl_o,
    output logic [REG_IDX_W-1:0] rs1_index_o,
    output logic [REG_IDX_W-1:0] rs2_index_o,
    output logic [REG_IDX_W-1:0] rd_index_o,
    output fwd_sel_t             fwd_sel_o,
    output logic [XLEN-1:0]      rs1_data_o,
    output logic [XLEN-1:0]      rs2_data_o,
    output logic [XLEN-1:0]      imm_data_o,
    output logic [XLEN-1:0]      rd_data_o,
    output logic                 jumpbranch_en_o,
    output logic [XLEN-1:0]      jumpbranch_addr_o
);

    ctrl_t           ctrl;
    fwd_sel_t        fwd_sel;
    logic [XLEN-1:0] rf_rs1_data;
    logic [XLEN-1:0] rf_rs2_data;
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;
    logic [XLEN-1:0] imm_data;
    logic [XLEN-1:0] jump_sum;
    logic            taken;

    function automatic logic [XLEN-1:0] operand(input src_sel_e        sel,
                                                input logic [XLEN-1:0] rf_data,
                                                input wb_bus_t         b_id2ex,
                                                input wb_bus_t         b_ex2mem,
                                                input wb_bus_t         b_mem2wb);
        case (sel)
            SRC_ID2EX:  return b_id2ex.rd_data;
            SRC_EX2MEM: return b_ex2mem.rd_data;
            SRC_MEM2WB: return b_mem2wb.rd_data;
            default:    return rf_data;
        endcase
    endfunction

    // ====================
    // Submodules
    // ====================
    id_control u_control (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .ctrl_o       (ctrl)
    );

    id_immgen u_immgen (
        .imm_type_i (ctrl.imm_type),
        .inst_i     (inst_i),
        .imm_data_o (imm_data)
    );

    id_regfile u_regfile (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .wb_i        (mem2wb_i),
        .rs1_index_i (inst_i.r.rs1),
        .rs2_index_i (inst_i.r.rs2),
        .rs1_data_o  (rf_rs1_data),
        .rs2_data_o  (rf_rs2_data)
    );

    id_forward u_forward (
        .clk         (clk),
        .rs1_en_i    (ctrl.rs1_en),
        .rs2_en_i    (ctrl.rs2_en),
        .rs1_index_i (inst_i.r.rs1),
        .rs2_index_i (inst_i.r.rs2),
        .id2ex_i     (id2ex_i),
        .ex2mem_i    (ex2mem_i),
        .mem2wb_i    (mem2wb_i),
        .fwd_sel_o   (fwd_sel)
    );

    id_branchjudge u_branchjudge (
        .comp_type_i (ctrl.comp_type),
        .rs1_data_i  (rs1_data),
        .rs2_data_i  (rs2_data),
        .taken_o     (taken)
    );

    // ====================
    // Operands and target
    // ====================
    assign rs1_data = operand(fwd_sel.rs1_src, rf_rs1_data, id2ex_i, ex2mem_i, mem2wb_i);
    assign rs2_data = operand(fwd_sel.rs2_src, rf_rs2_data, id2ex_i, ex2mem_i, mem2wb_i);

    assign jump_sum = (ctrl.jump_base_rs1 ? rs1_data : inst_addr_i) + imm_data;
    assign jumpbranch_addr_o = {jump_sum[XLEN-1:1], jump_sum[0] & ~ctrl.jump_base_rs1};
    assign jumpbranch_en_o   = ctrl.inst_jump | (ctrl.inst_branch & taken);

    assign rd_data_o   = ctrl.inst_lui ? imm_data : nxt_inst_addr_i;  // Link value.
    assign ctrl_o      = ctrl;
    assign fwd_sel_o   = fwd_sel;
    assign rs1_index_o = inst_i.r.rs1;
    assign rs2_index_o = inst_i.r.rs2;
    assign rd_index_o  = inst_i.r.rd;
    assign rs1_data_o  = rs1_data;
    assign rs2_data_o  = rs2_data;
    assign imm_data_o  = imm_data;

endmodule

`default_nettype wire

//--- id_top_tb.sv
`timescale 1ns/1ns
`default_nettype none

module id_top_tb import id_pkg::*; ();

    localparam int MAX_LINES   = 200;
    localparam int MIN_VECTORS = 20;
    localparam int MAX_CHARS   = 400;

    logic                 clk;
    logic                 arst_n;
    logic                 inst_valid;
    inst_t                inst;
    logic [XLEN-1:0]      inst_addr;
    logic [XLEN-1:0]      nxt_inst_addr;
    wb_bus_t              id2ex;
    wb_bus_t              ex2mem;
    wb_bus_t              mem2wb;

    ctrl_t                ctrl;
    logic [REG_IDX_W-1:0] rs1_index;
    logic [REG_IDX_W-1:0] rs2_index;
    logic [REG_IDX_W-1:0] rd_index;
    fwd_sel_t             fwd_sel;
    logic [XLEN-1:0]      rs1_data;
    logic [XLEN-1:0]      rs2_data;
    logic [XLEN-1:0]      imm_data;
    logic [XLEN-1:0]      rd_data;
    logic                 jumpbranch_en;
    logic [XLEN-1:0]      jumpbranch_addr;

    // One vector line as read from the file.
    int                   fd;
    int                   code;
    int                   line_no;
    int                   vec_count;
    logic                 at_eof;
    logic [8*8-1:0]       kind;
    logic                 v_valid;
    logic [INST_W-1:0]    v_inst;
    logic [XLEN-1:0]      v_addr;
    logic [XLEN-1:0]      v_nxt;
    logic                 id_en, ex_en, wb_en;
    logic [REG_IDX_W-1:0] id_idx, ex_idx, wb_idx;
    logic [XLEN-1:0]      id_data, ex_data, wb_data;
    logic                 x_rd_en;
    logic                 x_jb_en;
    logic [XLEN-1:0]      x_jb_addr, x_rs1, x_rs2, x_imm, x_rd;
    logic [1:0]           x_reads;

    id_top uut (
        .clk               (clk),
        .arst_n_i          (arst_n),
        .inst_valid_i      (inst_valid),
        .inst_i            (inst),
        .inst_addr_i       (inst_addr),
        .nxt_inst_addr_i   (nxt_inst_addr),
        .id2ex_i           (id2ex),
        .ex2mem_i          (ex2mem),
        .mem2wb_i          (mem2wb),
        .ctrl_o            (ctrl),
        .rs1_index_o       (rs1_index),
        .rs2_index_o       (rs2_index),
        .rd_index_o        (rd_index),
        .fwd_sel_o         (fwd_sel),
        .rs1_data_o        (rs1_data),
        .rs2_data_o        (rs2_data),
        .imm_data_o        (imm_data),
        .rd_data_o         (rd_data),
        .jumpbranch_en_o   (jumpbranch_en),
        .jumpbranch_addr_o (jumpbranch_addr)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ====================
    // Helpers
    // ====================
    task automatic abort_run(input string msg);
        $display("%0s", msg);
        $display("Simulation failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_value(input string name, input logic [XLEN-1:0] actual,
                               input logic [XLEN-1:0] expected);
        if (actual !== expected) begin
            abort_run($sformatf("CHECK FAILED %0s actual=0x%h expected=0x%h (line %0d)",
                                name, actual, expected, line_no));
        end
    endtask

    task automatic skip_line(input int fd_in);
        int ch;
        int count;
        count = 0;
        ch = $fgetc(fd_in);
        while ((ch != 10) && (ch != -1) && (count < MAX_CHARS)) begin
            ch = $fgetc(fd_in);
            count++;
        end
    endtask

    // Which of rs1 and rs2 an RV64I opcode reads.
    function automatic logic [1:0] operand_reads(input logic       valid,
                                                 input logic [6:0] opcode);
        logic [1:0] reads;
        reads = 2'b00;
        if (valid) begin
            case (opcode)
                OP_JALR, OP_LOAD, OP_IMM:   reads = 2'b10;
                OP_BRANCH, OP_STORE, OP_OP: reads = 2'b11;
                default:                    reads = 2'b00;
            endcase
        end
        return reads;
    endfunction

    // Oldest match first, so a younger stage overrides it.
    function automatic logic [1:0] expected_src(input logic                 en,
                                                input logic [REG_IDX_W-1:0] idx);
        logic [1:0] src;
        src = SRC_REG;
        if (en && (idx != '0)) begin
            if (wb_en && (wb_idx == idx)) begin
                src = SRC_MEM2WB;
            end
            if (ex_en && (ex_idx == idx)) begin
                src = SRC_EX2MEM;
            end
            if (id_en && (id_idx == idx)) begin
                src = SRC_ID2EX;
            end
        end
        return src;
    endfunction

    // ====================
    // Vector loop
    // ====================
    initial begin
        arst_n        = 1'b0;
        inst_valid    = 1'b0;
        inst          = '0;
        inst_addr     = '0;
        nxt_inst_addr = '0;
        id2ex         = '0;
        ex2mem        = '0;
        mem2wb        = '0;
        line_no       = 0;
        vec_count     = 0;
        at_eof        = 1'b0;
        fd = $fopen("id_top_vectors.txt", "r");
        if (fd == 0) begin
            abort_run("could not open the vector file id_top_vectors.txt");
        end
        repeat (16) @(posedge clk);
        arst_n <= 1'b1;
        while (!at_eof) begin
            line_no++;
            if (line_no > MAX_LINES) begin
                abort_run("vector file is longer than the line limit");
            end
            code = $fscanf(fd, "%s", kind);
            if (code != 1) begin
                at_eof = 1'b1;
            end else if (kind == "#") begin
                skip_line(fd);  // Column legend.
            end else begin
                code = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h",
                               v_valid, v_inst, v_addr, v_nxt,
                               id_en, id_idx, id_data, ex_en, ex_idx, ex_data);
                code += $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h",
                                wb_en, wb_idx, wb_data, x_rd_en, x_jb_en,
                                x_jb_addr, x_rs1, x_rs2, x_imm, x_rd);
                if (code != 20) begin
                    abort_run($sformatf("vector on line %0d is short or malformed", line_no));
                end
                @(posedge clk);
                inst_valid    <= v_valid;
                inst          <= v_inst;
                inst_addr     <= v_addr;
                nxt_inst_addr <= v_nxt;
                id2ex         <= {id_en, id_idx, id_data};
                ex2mem        <= {ex_en, ex_idx, ex_data};
                mem2wb        <= {wb_en, wb_idx, wb_data};
                @(negedge clk);  // Decode outputs settled.
                x_reads = operand_reads(v_valid, v_inst[6:0]);
                check_value("rd_en", ctrl.rd_en, x_rd_en);
                check_value("rs1_index_o", rs1_index, v_inst[19:15]);
                check_value("rs2_index_o", rs2_index, v_inst[24:20]);
                check_value("rd_index_o", rd_index, v_inst[11:7]);
                check_value("fwd_sel_o", fwd_sel,
                            {expected_src(x_reads[1], v_inst[19:15]),
                             expected_src(x_reads[0], v_inst[24:20])});
                check_value("jumpbranch_en_o", jumpbranch_en, x_jb_en);
                check_value("jumpbranch_addr_o", jumpbranch_addr, x_jb_addr);
                check_value("rs1_data_o", rs1_data, x_rs1);
                check_value("rs2_data_o", rs2_data, x_rs2);
                check_value("imm_data_o", imm_data, x_imm);
                check_value("rd_data_o", rd_data, x_rd);
                vec_count++;
            end
        end
        $fclose(fd);
        if (vec_count < MIN_VECTORS) begin
            abort_run($sformatf("vector file holds only %0d vectors", vec_count));
        end else begin
            $display("Simulation passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- id_top_vectors.txt
# kind valid inst addr nxt | id2ex en idx data | ex2mem en idx data | mem2wb en idx data
# expected rd_en jb_en jb_addr rs1_data rs2_data imm_data rd_data (all hex)
wr 0 00000000 0 4 0 0 0 0 0 0 1 1 5 0 0 0 0 0 0 4
wr 0 00000000 0 4 0 0 0 0 0 0 1 2 fffffffffffffffe 0 0 0 0 0 0 4
wr 0 00000000 0 4 0 0 0 0 0 0 1 0 dead 0 0 0 0 0 0 4
wr 0 00000000 0 4 0 0 0 0 0 0 1 5 1000 0 0 0 0 0 0 4
rd 1 00208233 100 104 0 0 0 0 0 0 0 0 0 1 0 100 5 fffffffffffffffe 0 104
rd 1 005003b3 104 108 0 0 0 0 0 0 0 0 0 1 0 104 0 1000 0 108
fwd 1 00208233 200 204 1 1 aaaa 1 1 bbbb 1 1 cccc 1 0 200 aaaa fffffffffffffffe 0 204
fwd 1 00208233 204 208 1 3 1111 1 2 bbbb 1 2 cccc 1 0 204 cccc bbbb 0 208
fwd 1 00018333 208 20c 0 0 0 0 0 0 1 3 7777 1 0 208 7777 0 0 20c
fwd 1 005003b3 20c 210 1 0 dead 1 0 beef 0 0 0 1 0 20c 0 1000 0 210
imm 1 fff08413 300 304 0 0 0 0 0 0 0 0 0 1 0 2ff cccc 0 ffffffffffffffff 304
imm 1 7ff00413 304 308 0 0 0 0 0 0 0 0 0 1 0 b03 0 0 7ff 308
imm 1 fe20bc23 308 30c 0 0 0 0 0 0 0 0 0 0 0 300 cccc cccc fffffffffffffff8 30c
imm 1 0232a223 30c 310 0 0 0 0 0 0 0 0 0 0 0 330 1000 7777 24 310
imm 1 800004b7 400 404 0 0 0 0 0 0 0 0 0 1 0 ffffffff80000400 0 0 ffffffff80000000 ffffffff80000000
imm 1 123454b7 404 408 0 0 0 0 0 0 0 0 0 1 0 12345404 0 7777 12345000 12345000
br 1 00208863 500 504 1 1 5 1 2 5 0 0 0 0 1 510 5 5 10 504
br 1 00209863 520 524 1 1 5 1 2 5 0 0 0 0 0 530 5 5 10 524
br 1 fe20c8e3 540 544 1 1 fffffffffffffffe 1 2 1 0 0 0 0 1 530 fffffffffffffffe 1 fffffffffffffff0 544
br 1 fe20d8e3 560 564 1 1 fffffffffffffffe 1 2 1 0 0 0 0 0 550 fffffffffffffffe 1 fffffffffffffff0 564
br 1 0020e863 580 584 1 1 fffffffffffffffe 1 2 1 0 0 0 0 0 590 fffffffffffffffe 1 10 584
br 1 0020f863 5a0 5a4 1 1 fffffffffffffffe 1 2 1 0 0 0 0 1 5b0 fffffffffffffffe 1 10 5a4
jmp 1 100000ef 600 604 0 0 0 0 0 0 0 0 0 1 1 700 0 0 100 604
jmp 1 fe1ff06f 620 624 0 0 0 0 0 0 0 0 0 1 1 600 0 cccc ffffffffffffffe0 624
jmp 1 003280e7 640 644 0 0 0 0 0 0 0 0 0 1 1 1002 1000 7777 3 644
jmp 1 ffb10067 660 664 1 2 2002 0 0 0 0 0 0 1 1 1ffc 2002 0 fffffffffffffffb 664
inv 0 00208863 700 704 1 1 5 1 2 5 0 0 0 0 0 700 cccc cccc 0 704
inv 1 0020827f 720 724 0 0 0 0 0 0 0 0 0 0 0 720 cccc cccc 0 724

//--- id_top.f
id_pkg.sv
id_control.sv
id_immgen.sv
id_regfile.sv
id_forward.sv
id_branchjudge.sv
id_top.sv
id_top_tb.sv
